// ==== Makefile ====
TOP = tb_ahb_sram

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module ahb_sram_subsys

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) \
		--Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -qF '** FAIL **' sim.log
	grep -qF '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== ahb_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module ahb_decoder
   import ahb_sram_pkg::*;
(
   input  wire                HCLK,
   input  wire                HRESETn,
   input  wire                hsel,
   input  wire  [HADDR_W-1:0] haddr,
   input  wire  [1:0]         htrans,
   input  wire                hready,
   input  wire  [31:0]        hrdata_0,
   input  wire  [31:0]        hrdata_1,
   output logic               hsel_0,
   output logic               hsel_1,
   output logic [31:0]        hrdata,
   output logic               hreadyout,
   output logic               hresp
);

logic [HADDR_W-DECODE_LSB-1:0] region;     // Region bits of address
logic                          hit_0;
logic                          hit_1;
logic                          hsel_def;   // Unmapped, goes to default slave
logic                          trans_req;  // NONSEQ or SEQ
logic                          dp_0;       // Bank 0 owns data phase
logic                          dp_1;       // Bank 1 owns data phase
logic [1:0]                    ds_state;
logic [1:0]                    ds_next;

// ----------------------------------------------------------------------
// Address decode
// ----------------------------------------------------------------------
assign region    = haddr[HADDR_W-1:DECODE_LSB];
assign hit_0     = (region == BANK0_BASE[HADDR_W-1:DECODE_LSB]);
assign hit_1     = (region == BANK1_BASE[HADDR_W-1:DECODE_LSB]);
assign hsel_0    = hsel && hit_0;
assign hsel_1    = hsel && hit_1;
assign hsel_def  = hsel && !hit_0 && !hit_1;
assign trans_req = !((htrans == HTRANS_IDLE) || (htrans == HTRANS_BUSY));

// Data phase owner, moves only with ready
always_ff @(posedge HCLK or negedge HRESETn)
begin
   if (!HRESETn)
   begin
      dp_0 <= 1'b0;
      dp_1 <= 1'b0;
   end
   else if (hready)
   begin
      dp_0 <= hsel_0;
      dp_1 <= hsel_1;
   end
end

always_comb
begin
   case ({dp_1, dp_0})
      2'b01:   hrdata = hrdata_0;
      2'b10:   hrdata = hrdata_1;
      default: hrdata = 32'h0000_0000;    // Default slave or no owner
   endcase
end

// ----------------------------------------------------------------------
// Default slave
// ----------------------------------------------------------------------
always_comb
begin
   case (ds_state)
      DS_IDLE, DS_ERR2: ds_next = (hready && hsel_def && trans_req) ? DS_ERR1 : DS_IDLE;
      DS_ERR1:          ds_next = DS_ERR2;  // Always two cycles
      default:          ds_next = DS_IDLE;
   endcase
end

always_ff @(posedge HCLK or negedge HRESETn)
begin
   if (!HRESETn)
      ds_state <= DS_IDLE;
   else
      ds_state <= ds_next;
end

// Banks are zero wait, so only the default slave stalls
assign hreadyout = (ds_state != DS_ERR1);
assign hresp     = (ds_state == DS_IDLE) ? HRESP_OKAY : HRESP_ERROR;

// ERROR opens with a stall cycle and no bank owning the data phase
a_err_first: assert property (@(posedge HCLK) disable iff (!HRESETn)
   $rose(hresp) |-> (!hreadyout && !dp_0 && !dp_1))
   else $error("ahb_decoder: ERROR began without a stall cycle or beside a bank");

endmodule

`default_nettype wire

// ==== ahb_sram_pkg.sv ====
`default_nettype none

package ahb_sram_pkg;

   // ----------------------------------------------------------------------
   // Memory map
   // ----------------------------------------------------------------------
   localparam int                   HADDR_W    = 32;               // System address width
   localparam int                   BANK_AW    = 12;               // 4 KiB per bank
   localparam int                   BANK_WORDS = 2 ** (BANK_AW - 2);
   localparam logic [HADDR_W-1:0]   BANK0_BASE = 32'h0000_0000;
   localparam logic [HADDR_W-1:0]   BANK1_BASE = 32'h0000_1000;
   localparam int                   DECODE_LSB = 12;               // Lowest region select bit

   // AHB transfer types
   localparam logic [1:0] HTRANS_IDLE   = 2'b00;
   localparam logic [1:0] HTRANS_BUSY   = 2'b01;
   localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
   localparam logic [1:0] HTRANS_SEQ    = 2'b11;

   // AHB transfer sizes, 32-bit bus only
   localparam logic [2:0] HSIZE_BYTE = 3'b000;
   localparam logic [2:0] HSIZE_HALF = 3'b001;
   localparam logic [2:0] HSIZE_WORD = 3'b010;

   localparam logic HRESP_OKAY  = 1'b0;
   localparam logic HRESP_ERROR = 1'b1;

   // Default slave FSM encoding
   localparam logic [1:0] DS_IDLE = 2'd0;
   localparam logic [1:0] DS_ERR1 = 2'd1;                          // Stall cycle of ERROR
   localparam logic [1:0] DS_ERR2 = 2'd2;                          // Completion cycle of ERROR

endpackage

`default_nettype wire

// ==== ahb_sram_subsys.sv ====
`timescale 1ns/100ps
`default_nettype none

module ahb_sram_subsys
   import ahb_sram_pkg::*;
(
   input  wire                HCLK,
   input  wire                HRESETn,
   input  wire                HSEL,
   input  wire  [HADDR_W-1:0] HADDR,
   input  wire  [1:0]         HTRANS,
   input  wire  [2:0]         HSIZE,
   input  wire                HWRITE,
   input  wire  [31:0]        HWDATA,
   output logic [31:0]        HRDATA,
   output logic               HREADYOUT,  // Also the system ready
   output logic               HRESP
);

logic               hsel_0;
logic               hsel_1;
logic [31:0]        hrdata_0;
logic [31:0]        hrdata_1;
logic [BANK_AW-3:0] sram_addr_0;
logic [BANK_AW-3:0] sram_addr_1;
logic [3:0]         sram_wen_0;
logic [3:0]         sram_wen_1;
logic [31:0]        sram_wdata_0;
logic [31:0]        sram_wdata_1;
logic               sram_cs_0;
logic               sram_cs_1;
logic [31:0]        sram_rdata_0;
logic [31:0]        sram_rdata_1;

// ----------------------------------------------------------------------
// Decode and response mux, ready looped back as HREADY
// ----------------------------------------------------------------------
ahb_decoder u_dec (
   .HCLK(HCLK), .HRESETn(HRESETn), .hsel(HSEL), .haddr(HADDR), .htrans(HTRANS),
   .hready(HREADYOUT), .hrdata_0(hrdata_0), .hrdata_1(hrdata_1),
   .hsel_0(hsel_0), .hsel_1(hsel_1), .hrdata(HRDATA), .hreadyout(HREADYOUT), .hresp(HRESP)
);

// Bank 0
ahb_to_sram #(.AW(BANK_AW)) u_br0 (
   .HCLK(HCLK), .HRESETn(HRESETn), .hsel(hsel_0), .hready(HREADYOUT), .htrans(HTRANS),
   .hsize(HSIZE), .hwrite(HWRITE), .haddr(HADDR[BANK_AW-1:0]), .hwdata(HWDATA),
   .hrdata(hrdata_0), .sram_rdata(sram_rdata_0), .sram_addr(sram_addr_0),
   .sram_wen(sram_wen_0), .sram_wdata(sram_wdata_0), .sram_cs(sram_cs_0)
);

sram_bank u_ram0 (
   .HCLK(HCLK), .cs(sram_cs_0), .wen(sram_wen_0), .addr(sram_addr_0),
   .wdata(sram_wdata_0), .rdata(sram_rdata_0)
);

// Bank 1
ahb_to_sram #(.AW(BANK_AW)) u_br1 (
   .HCLK(HCLK), .HRESETn(HRESETn), .hsel(hsel_1), .hready(HREADYOUT), .htrans(HTRANS),
   .hsize(HSIZE), .hwrite(HWRITE), .haddr(HADDR[BANK_AW-1:0]), .hwdata(HWDATA),
   .hrdata(hrdata_1), .sram_rdata(sram_rdata_1), .sram_addr(sram_addr_1),
   .sram_wen(sram_wen_1), .sram_wdata(sram_wdata_1), .sram_cs(sram_cs_1)
);

sram_bank u_ram1 (
   .HCLK(HCLK), .cs(sram_cs_1), .wen(sram_wen_1), .addr(sram_addr_1),
   .wdata(sram_wdata_1), .rdata(sram_rdata_1)
);

endmodule

`default_nettype wire

// ==== ahb_to_sram.sv ====
`timescale 1ns/100ps
`default_nettype none

module ahb_to_sram
   import ahb_sram_pkg::*;
#(
   parameter int AW = BANK_AW                   // Byte address width of the bank
)
(
   input  wire           HCLK,
   input  wire           HRESETn,
   input  wire           hsel,                  // Bank select from decoder
   input  wire           hready,                // System ready
   input  wire  [1:0]    htrans,
   input  wire  [2:0]    hsize,
   input  wire           hwrite,
   input  wire  [AW-1:0] haddr,
   input  wire  [31:0]   hwdata,                // Valid in data phase
   output logic [31:0]   hrdata,
   input  wire  [31:0]   sram_rdata,            // One cycle after read select
   output logic [AW-3:0] sram_addr,             // Word address
   output logic [3:0]    sram_wen,              // Byte enables, active high
   output logic [31:0]   sram_wdata,
   output logic          sram_cs
);

logic          access;                          // Accepted address phase
logic          acc_wr;
logic          acc_rd;
logic [3:0]    lanes;                           // Lanes of current address phase
logic          wr_dphase;                       // Write data phase in progress
logic [AW-3:0] buf_addr;                        // Word address of buffered write
logic [3:0]    buf_lanes;                       // Lanes valid in buffer
logic [31:0]   buf_data;                        // Buffered write bytes
logic          buf_pend;                        // Write held back by reads
logic          ram_write;                       // SRAM port free for the write
logic          rd_hit;                          // Read data phase hits buffer

// ----------------------------------------------------------------------
// Address phase decode
// ----------------------------------------------------------------------
assign access = hsel && hready && ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));
assign acc_wr = access && hwrite;
assign acc_rd = access && !hwrite;

// Byte lanes from size and low address bits
always_comb
begin
   case (hsize)
      HSIZE_BYTE: lanes = 4'b0001 << haddr[1:0];
      HSIZE_HALF: lanes = haddr[1] ? 4'b1100 : 4'b0011;
      HSIZE_WORD: lanes = 4'b1111;
      default:    lanes = 4'b0000;              // Wider than the bus
   endcase
end

// Write address and lanes captured at address phase
always_ff @(posedge HCLK or negedge HRESETn)
begin
   if (!HRESETn)
   begin
      wr_dphase <= 1'b0;
      buf_addr  <= '0;
      buf_lanes <= 4'b0000;
   end
   else
   begin
      wr_dphase <= acc_wr;
      if (acc_wr)
      begin
         buf_addr  <= haddr[AW-1:2];
         buf_lanes <= lanes;
      end
   end
end

// Write bytes captured in data phase
always_ff @(posedge HCLK)
begin
   for (int i = 0; i < 4; i++)
   begin
      if (wr_dphase && buf_lanes[i])
         buf_data[8*i +: 8] <= hwdata[8*i +: 8];
   end
end

// ----------------------------------------------------------------------
// SRAM port sharing
// ----------------------------------------------------------------------
// A read address phase owns the port, so a write in flight waits
assign ram_write = (buf_pend || wr_dphase) && !acc_rd;

always_ff @(posedge HCLK or negedge HRESETn)
begin
   if (!HRESETn)
      buf_pend <= 1'b0;
   else
      buf_pend <= (buf_pend || wr_dphase) && acc_rd; // Held while reads continue
end

assign sram_cs    = acc_rd || ram_write;
assign sram_addr  = acc_rd ? haddr[AW-1:2] : buf_addr;
assign sram_wen   = {4{ram_write}} & buf_lanes;
assign sram_wdata = buf_pend ? buf_data : hwdata; // Fresh write goes straight through

// ----------------------------------------------------------------------
// Read merge
// ----------------------------------------------------------------------
// Read of the buffered word sees bytes not yet in SRAM
always_ff @(posedge HCLK or negedge HRESETn)
begin
   if (!HRESETn)
      rd_hit <= 1'b0;
   else
      rd_hit <= acc_rd && (haddr[AW-1:2] == buf_addr);
end

always_comb
begin
   for (int i = 0; i < 4; i++)
   begin
      hrdata[8*i +: 8] = (rd_hit && buf_lanes[i]) ? buf_data[8*i +: 8]
                                                  : sram_rdata[8*i +: 8];
   end
end

// Write strobes never reach an unselected SRAM
a_wen_cs: assert property (@(posedge HCLK) disable iff (!HRESETn)
   (|sram_wen) |-> sram_cs)
   else $error("ahb_to_sram: sram_wen set without sram_cs");

// Pending write drains on the first cycle without a read
a_pend_drain: assert property (@(posedge HCLK) disable iff (!HRESETn)
   (buf_pend && !acc_rd) |-> (|sram_wen) ##1 !buf_pend)
   else $error("ahb_to_sram: pending write survived a free cycle");

endmodule

`default_nettype wire

// ==== list.f ====
ahb_sram_pkg.sv
sram_bank.sv
ahb_to_sram.sv
ahb_decoder.sv
ahb_sram_subsys.sv
tb_ahb_sram.sv

// ==== sram_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

module sram_bank
   import ahb_sram_pkg::*;
(
   input  wire                HCLK,
   input  wire                cs,           // Chip select, active high
   input  wire  [3:0]         wen,          // Byte write enables
   input  wire  [BANK_AW-3:0] addr,         // Word address
   input  wire  [31:0]        wdata,
   output logic [31:0]        rdata         // Registered read data
);

logic [31:0] mem [BANK_WORDS];

// ----------------------------------------------------------------------
// Single port access
// ----------------------------------------------------------------------
always_ff @(posedge HCLK)
begin
   if (cs)
   begin
      for (int i = 0; i < 4; i++)
      begin
         if (wen[i])
            mem[addr][8*i +: 8] <= wdata[8*i +: 8]; // Each lane on its own
      end
      if (wen == 4'b0000)
         rdata <= mem[addr];                // Read cycle
   end
end
// Output holds between reads

// No write strobe without select
a_wen_needs_cs: assert property (@(posedge HCLK)
   !cs |-> (wen == 4'b0000))
   else $error("sram_bank: wen active while cs low");

endmodule

`default_nettype wire

// ==== tb_ahb_sram.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_ahb_sram
   import ahb_sram_pkg::*;
();

logic        HCLK;
logic        HRESETn;
logic        HSEL;
logic [31:0] HADDR;
logic [1:0]  HTRANS;
logic [2:0]  HSIZE;
logic        HWRITE;
logic [31:0] HWDATA;
wire  [31:0] HRDATA;
wire         HREADYOUT;
wire         HRESP;

// State of the data phase now on the bus
logic        dp_rd = 1'b0;
logic        dp_wr = 1'b0;
logic        dp_err = 1'b0;
logic        dp_start = 1'b0;                   // First cycle of the data phase
logic [31:0] dp_exp = '0;                       // Predicted read data
logic [31:0] dp_mask = '0;                      // Bits to compare
// Prediction for the address phase just issued
logic        nxt_rd = 1'b0;
logic        nxt_wr = 1'b0;
logic        nxt_err = 1'b0;
logic [31:0] nxt_exp = '0;
logic [31:0] nxt_mask = '0;
logic [31:0] nxt_wdata = '0;
logic [31:0] ref_data  [int unsigned];          // Reference memory by word address
logic [3:0]  ref_valid [int unsigned];          // Lanes written so far
int          cycles = 0;

ahb_sram_subsys u_dut (
   .HCLK(HCLK), .HRESETn(HRESETn), .HSEL(HSEL), .HADDR(HADDR), .HTRANS(HTRANS),
   .HSIZE(HSIZE), .HWRITE(HWRITE), .HWDATA(HWDATA), .HRDATA(HRDATA),
   .HREADYOUT(HREADYOUT), .HRESP(HRESP)
);

initial
begin
   HCLK = 1'b0;
   forever #20 HCLK = ~HCLK;                    // 40 ns period
end

// Run limit, about twice what the tests need
always @(posedge HCLK)
begin
   cycles <= cycles + 1;
   if (cycles == 3000)
   begin
      $display("Timeout: the tests did not finish within 3000 cycles");
      $display("** FAIL **");
      $fatal(1, "Run stopped by timeout");
   end
end

task automatic fail_now(input string msg);
   $display("ERROR: time %0t: %s", $time, msg);
   $display("** FAIL **");
   $fatal(1, "Stopped at first error");
endtask

// Lanes covered by 2**size bytes starting at the byte offset
function automatic logic [3:0] byte_lanes(input logic [2:0] size, input logic [1:0] off);
   int         nbytes;
   logic [3:0] ln;
   nbytes = 1 << size;
   ln = 4'b0000;
   for (int i = 0; i < 4; i++)
      if ((i >= int'(off)) && (i < int'(off) + nbytes))
         ln[i] = 1'b1;
   return ln;
endfunction

function automatic logic [31:0] lane_mask(input logic [3:0] ln);
   return {{8{ln[3]}}, {8{ln[2]}}, {8{ln[1]}}, {8{ln[0]}}};
endfunction

// ----------------------------------------------------------------------
// Pipelined master, one address phase per call
// ----------------------------------------------------------------------
task automatic bus_cycle(input logic sel, input logic [1:0] trans, input logic wr,
                         input logic [31:0] addr, input logic [2:0] size,
                         input logic [31:0] wdata);
   logic        rdy;
   logic        mapped;
   logic [3:0]  ln;
   logic [31:0] word;
   int unsigned wa;
   mapped = (addr[HADDR_W-1:DECODE_LSB] == BANK0_BASE[HADDR_W-1:DECODE_LSB]) ||
            (addr[HADDR_W-1:DECODE_LSB] == BANK1_BASE[HADDR_W-1:DECODE_LSB]);
   ln = byte_lanes(size, addr[1:0]);
   wa = addr[31:2];
   HWDATA   <= nxt_wdata;                       // Data phase of the previous transfer
   dp_rd    <= nxt_rd;
   dp_wr    <= nxt_wr;
   dp_err   <= nxt_err;
   dp_exp   <= nxt_exp;
   dp_mask  <= nxt_mask;
   dp_start <= 1'b1;
   HSEL     <= sel;
   HTRANS   <= trans;
   HADDR    <= addr;
   HSIZE    <= size;
   HWRITE   <= wr;
   nxt_wdata = wdata;
   nxt_rd  = 1'b0;
   nxt_wr  = 1'b0;
   nxt_err = 1'b0;
   if (sel && ((trans == HTRANS_NONSEQ) || (trans == HTRANS_SEQ)))
   begin
      if (!ref_data.exists(wa))
      begin
         ref_data[wa]  = 32'h0;
         ref_valid[wa] = 4'b0000;
      end
      if (!mapped)
         nxt_err = 1'b1;                        // Default slave answers
      else if (wr)
      begin
         nxt_wr = 1'b1;
         word = ref_data[wa];
         word = (word & ~lane_mask(ln)) | (wdata & lane_mask(ln)); // Latest byte wins
         ref_data[wa]  = word;
         ref_valid[wa] = ref_valid[wa] | ln;
      end
      else
      begin
         nxt_rd   = 1'b1;
         nxt_exp  = ref_data[wa];
         nxt_mask = lane_mask(ln & ref_valid[wa]); // Unwritten bytes unknown
      end
   end
   // Address phase is taken on the edge where HREADYOUT was high
   do
   begin
      @(negedge HCLK);
      rdy = HREADYOUT;
      @(posedge HCLK);
      dp_start <= 1'b0;
   end
   while (!rdy);
endtask

task automatic write_xfer(input logic [31:0] addr, input logic [2:0] size,
                          input logic [31:0] data);
   bus_cycle(1'b1, HTRANS_NONSEQ, 1'b1, addr, size, data);
endtask

task automatic read_xfer(input logic [31:0] addr, input logic [2:0] size);
   bus_cycle(1'b1, HTRANS_NONSEQ, 1'b0, addr, size, $urandom);
endtask

// IDLE write on a word that the random reads cover
task automatic idle_cycle();
   bus_cycle(1'b1, HTRANS_IDLE, 1'b1, BANK0_BASE + 32'h3C, HSIZE_WORD, $urandom);
endtask

// Active transfer with HSEL low must leave both banks alone
task automatic deselect_cycle();
   bus_cycle(1'b0, HTRANS_NONSEQ, 1'b1, BANK1_BASE + 32'h3C, HSIZE_WORD, $urandom);
endtask

// ----------------------------------------------------------------------
// Checks
// ----------------------------------------------------------------------
a_read_data: assert property (@(posedge HCLK) disable iff (!HRESETn)
   dp_rd |-> ((HRDATA & dp_mask) == (dp_exp & dp_mask)))
   else fail_now($sformatf("read data %h, expected %h under mask %h",
                           $sampled(HRDATA), $sampled(dp_exp), $sampled(dp_mask)));

a_mapped_okay: assert property (@(posedge HCLK) disable iff (!HRESETn)
   (dp_rd || dp_wr) |-> (HREADYOUT && (HRESP == HRESP_OKAY)))
   else fail_now("mapped transfer not completed with zero-wait OKAY");

a_idle_okay: assert property (@(posedge HCLK) disable iff (!HRESETn)
   (!dp_rd && !dp_wr && !dp_err) |-> (HREADYOUT && (HRESP == HRESP_OKAY)))
   else fail_now("idle or deselected cycle not answered with OKAY");

a_err_two_cycle: assert property (@(posedge HCLK) disable iff (!HRESETn)
   (dp_err && dp_start) |-> (!HREADYOUT && (HRESP == HRESP_ERROR))
                            ##1 (HREADYOUT && (HRESP == HRESP_ERROR)))
   else fail_now("unmapped transfer did not get the two-cycle ERROR response");

// ----------------------------------------------------------------------
// Stimulus
// ----------------------------------------------------------------------
initial
begin
   logic [31:0] addr;
   logic [2:0]  size;
   void'($urandom(32'h3362));
   HRESETn = 1'b0;
   HSEL    = 1'b0;
   HADDR   = 32'h0;
   HTRANS  = HTRANS_IDLE;
   HSIZE   = HSIZE_WORD;
   HWRITE  = 1'b0;
   HWDATA  = 32'h0;
   repeat (16) @(posedge HCLK);
   HRESETn <= 1'b1;
   @(posedge HCLK);

   for (int i = 0; i < 4; i++)                  // Word write, read later
   begin
      write_xfer(BANK0_BASE + 32'h100 * i + 4, HSIZE_WORD, 32'hA500_0000 + i);
      write_xfer(BANK1_BASE + 32'hFFC - 32'h40 * i, HSIZE_WORD, 32'h5A00_0000 + i);
   end
   for (int i = 0; i < 4; i++)
   begin
      read_xfer(BANK0_BASE + 32'h100 * i + 4, HSIZE_WORD);
      read_xfer(BANK1_BASE + 32'hFFC - 32'h40 * i, HSIZE_WORD);
   end

   for (int b = 0; b < 2; b++)                  // Partial writes at every lane
   begin
      addr = (b == 0) ? BANK0_BASE + 32'h200 : BANK1_BASE + 32'h204;
      write_xfer(addr, HSIZE_WORD, 32'h1122_3344);
      for (int o = 0; o < 4; o++)
      begin
         write_xfer(addr + o, HSIZE_BYTE, {4{8'hC0 + 8'(o)}});
         idle_cycle();
         read_xfer(addr, HSIZE_WORD);
         read_xfer(addr + o, HSIZE_BYTE);
      end
      write_xfer(addr, HSIZE_HALF, 32'hBEEF_F00D);
      read_xfer(addr, HSIZE_WORD);
      write_xfer(addr + 2, HSIZE_HALF, 32'hCAFE_0000);
      read_xfer(addr + 2, HSIZE_HALF);
   end

   addr = BANK0_BASE + 32'h300;                 // Read right behind write
   write_xfer(addr, HSIZE_WORD, 32'hDEAD_BEEF);
   write_xfer(addr + 1, HSIZE_BYTE, 32'h0000_7700);
   read_xfer(addr, HSIZE_WORD);
   write_xfer(addr + 2, HSIZE_HALF, 32'h1234_0000);
   read_xfer(addr + 32'h10, HSIZE_WORD);        // Reads keep the write pending
   read_xfer(BANK0_BASE + 32'h204, HSIZE_WORD);
   read_xfer(addr, HSIZE_WORD);
   read_xfer(addr + 3, HSIZE_BYTE);

   write_xfer(BANK0_BASE + 32'h80, HSIZE_WORD, 32'h0BAD_0000); // Same offset, both banks
   write_xfer(BANK1_BASE + 32'h80, HSIZE_WORD, 32'h0BAD_1111);
   read_xfer(BANK0_BASE + 32'h80, HSIZE_WORD);
   read_xfer(BANK1_BASE + 32'h80, HSIZE_WORD);

   write_xfer(32'h0000_2000, HSIZE_WORD, 32'hFFFF_0000); // Unmapped
   read_xfer(32'h8000_0010, HSIZE_WORD);
   read_xfer(BANK1_BASE + 32'h80, HSIZE_WORD);
   idle_cycle();
   read_xfer(32'hFFFF_FFFC, HSIZE_BYTE);
   write_xfer(BANK0_BASE + 32'h80, HSIZE_BYTE, 32'h0000_0042);

   for (int n = 0; n < 600; n++)                // Random traffic over a small window
   begin
      if ($urandom_range(0, 7) == 0)
         idle_cycle();
      else if ($urandom_range(0, 7) == 0)
         deselect_cycle();
      size = 3'($urandom_range(0, 2));
      addr = ($urandom_range(0, 1) == 1) ? BANK1_BASE : BANK0_BASE;
      addr = addr + (32'($urandom_range(0, 15)) << 2);
      if (size == HSIZE_BYTE)
         addr[1:0] = 2'($urandom_range(0, 3));
      else if (size == HSIZE_HALF)
         addr[1] = 1'($urandom_range(0, 1));
      if ($urandom_range(0, 1) == 1)
         write_xfer(addr, size, $urandom);
      else
         read_xfer(addr, size);
   end
   idle_cycle();                                // Flush the last data phase
   idle_cycle();

   $display("** PASS **");
   $finish;
end

endmodule

`default_nettype wire
